// File: list.f
isa_pkg.sv
ooo_pkg.sv
dispatch_unit.sv
res_station.sv
stage_is.sv
alu_fu.sv
ooo_issue_top.sv
tb_ooo_issue.sv

// File: Bender.yml
package:
  name: ooo_issue

sources:
  - isa_pkg.sv
  - ooo_pkg.sv
  - dispatch_unit.sv
  - res_station.sv
  - stage_is.sv
  - alu_fu.sv
  - ooo_issue_top.sv
  - target: test
    files:
      - tb_ooo_issue.sv

// File: tb_ooo_issue.sv
// testbench for the out-of-order issue slice
// rows from a stimulus table go in through the input handshake; a sink
// answers the result channel after a per-row ack delay and a tag-indexed
// scoreboard checks every result against the reference model
`timescale 1ns/1ps

module tb_ooo_issue;
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int RS_SIZE  = 4;
    localparam int NUM_ROWS = 30;
    localparam int NUM_SECS = 4;
    localparam int LIMIT    = 40 * NUM_ROWS + 200; // watchdog, in cycles
    localparam int NTAGS    = 2 ** TAG_W;

    logic             clock;
    logic             rst;
    logic             in_req;
    logic             in_ack;
    alu_func_e        in_func;
    logic [TAG_W-1:0] in_dst_tag;
    logic [XLEN-1:0]  in_opa;
    logic             in_opa_is_tag;
    logic [XLEN-1:0]  in_opb;
    logic             in_opb_is_tag;
    logic             res_req;
    logic             res_ack;
    logic [TAG_W-1:0] res_tag;
    logic [XLEN-1:0]  res_value;

    // stimulus table, row_exp is filled by the reference model
    string            row_name  [NUM_ROWS];
    int               row_sec   [NUM_ROWS]; // section the row belongs to
    alu_func_e        row_func  [NUM_ROWS];
    logic [TAG_W-1:0] row_dst   [NUM_ROWS];
    logic [XLEN-1:0]  row_opa   [NUM_ROWS];
    logic             row_a_tag [NUM_ROWS];
    logic [XLEN-1:0]  row_opb   [NUM_ROWS];
    logic             row_b_tag [NUM_ROWS];
    int               row_delay [NUM_ROWS]; // sink ack delay, -1 is random
    logic [XLEN-1:0]  row_exp   [NUM_ROWS];
    int               n_rows = 0;

    // scoreboard for the running section, indexed by tag
    logic sec_live [NTAGS];
    int   seen_cnt [NTAGS];
    int   tag_row  [NTAGS];
    int   ack_wait [NTAGS];

    int mismatches = 0;
    int other_errs = 0;
    int cycle_cnt  = 0;

    ooo_issue_top #(.RS_SIZE(RS_SIZE)) ooo_issue_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock; // 20 ns period
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [XLEN-1:0] alu_ref(alu_func_e f, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0]; // shift amount is 5 bits
            ALU_SRL: return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    // program order walk, producers always come first
    task automatic resolve_rows();
        logic [XLEN-1:0] tag_val [NTAGS];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int i = 0; i < n_rows; i++) begin
            a = row_a_tag[i] ? tag_val[row_opa[i][TAG_W-1:0]] : row_opa[i];
            b = row_b_tag[i] ? tag_val[row_opb[i][TAG_W-1:0]] : row_opb[i];
            row_exp[i] = alu_ref(row_func[i], a, b);
            tag_val[row_dst[i]] = row_exp[i]; // later reuse of a tag overwrites
        end
    endtask

    task automatic add_row(string name, int sec, alu_func_e f, logic [TAG_W-1:0] dst,
                           logic [XLEN-1:0] a, logic a_tag, logic [XLEN-1:0] b,
                           logic b_tag, int dly);
        row_name[n_rows]  = name;
        row_sec[n_rows]   = sec;
        row_func[n_rows]  = f;
        row_dst[n_rows]   = dst;
        row_opa[n_rows]   = a;
        row_a_tag[n_rows] = a_tag;
        row_opb[n_rows]   = b;
        row_b_tag[n_rows] = b_tag;
        row_delay[n_rows] = dly;
        n_rows++;
    endtask

    task automatic build_table();
        // independent rows, one per opcode
        add_row("add_lit", 0, ALU_ADD, 4'd1, 32'h1234_5678, 0, 32'h0fed_cba9, 0, 0);
        add_row("sub_lit", 0, ALU_SUB, 4'd2, 32'h0000_0010, 0, 32'h0000_0020, 0, 1);
        add_row("and_lit", 0, ALU_AND, 4'd3, 32'hf0f0_1234, 0, 32'h0ff0_ffff, 0, 2);
        add_row("or_lit",  0, ALU_OR,  4'd4, 32'h1200_0000, 0, 32'h0034_5600, 0, 0);
        add_row("xor_lit", 0, ALU_XOR, 4'd5, 32'haaaa_5555, 0, 32'hffff_0000, 0, 3);
        add_row("sll_lit", 0, ALU_SLL, 4'd6, 32'h0000_0003, 0, 32'h0000_0024, 0, 1);
        add_row("srl_lit", 0, ALU_SRL, 4'd7, 32'h8000_0000, 0, 32'hffff_ffff, 0, 0);
        // chains; head delay 1 makes the producer broadcast meet the consumer write
        add_row("chain_head", 1, ALU_ADD, 4'd0, 32'd5, 0, 32'd6, 0, 1);
        add_row("chain_prod", 1, ALU_XOR, 4'd1, 32'h0ff, 0, 32'hf0f, 0, 6);
        add_row("chain_same_cycle", 1, ALU_ADD, 4'd2, 32'd1, 1, 32'h10, 0, 0);
        add_row("chain_sll", 1, ALU_SLL, 4'd3, 32'd2, 1, 32'd4, 0, 2);
        add_row("chain_sub", 1, ALU_SUB, 4'd4, 32'd3, 1, 32'd2, 1, 0);
        add_row("chain_or",  1, ALU_OR,  4'd5, 32'd4, 1, 32'd3, 1, 1);
        // back-pressure, long ack on the first row fills the station
        add_row("bp_block", 2, ALU_AND, 4'd0, 32'hffff_0000, 0, 32'h1234_5678, 0, 80);
        add_row("bp_add",  2, ALU_ADD, 4'd1, 32'd100, 0, 32'd23, 0, 0);
        add_row("bp_sub",  2, ALU_SUB, 4'd2, 32'd7, 0, 32'd9, 0, 0);
        add_row("bp_or",   2, ALU_OR,  4'd3, 32'h00f0_0000, 0, 32'h0000_0f0f, 0, 0);
        add_row("bp_xor",  2, ALU_XOR, 4'd4, 32'h5a5a_5a5a, 0, 32'h0f0f_0f0f, 0, 0);
        add_row("bp_dep",  2, ALU_ADD, 4'd5, 32'd4, 1, 32'h1000, 0, 0);
        add_row("bp_dep2", 2, ALU_SRL, 4'd6, 32'd5, 1, 32'd3, 0, 0);
        // random operands and random sink delays
        for (int k = 0; k < 10; k++) begin
            add_row($sformatf("rand_%0d", k), 3, alu_func_e'(k % 7), TAG_W'(k),
                    $urandom, 0, $urandom, 0, -1);
        end
    endtask

    ////////////////////////////////////////
    // driver and sink
    ////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clock);
        #2; // drive and sample just after the edge
    endtask

    // one full four-phase transfer on the input channel
    task automatic send_row(int i);
        while (in_ack) next_cycle(); // previous ack must be low
        in_func       = row_func[i];
        in_dst_tag    = row_dst[i];
        in_opa        = row_opa[i];
        in_opa_is_tag = row_a_tag[i];
        in_opb        = row_opb[i];
        in_opb_is_tag = row_b_tag[i];
        in_req        = 1'b1;
        do next_cycle(); while (!in_ack); // waits out a full station
        in_req = 1'b0;
        do next_cycle(); while (in_ack);
    endtask

    task automatic score_result();
        int r;
        if (!sec_live[res_tag]) begin
            $display("unexpected tag %0d on the result channel at %0t", res_tag, $time);
            other_errs++;
        end else begin
            r = tag_row[res_tag];
            seen_cnt[res_tag]++;
            if (res_value !== row_exp[r]) begin
                $display("mismatch %s tag %0d expected %h actual %h",
                         row_name[r], res_tag, row_exp[r], res_value);
                mismatches++;
            end
        end
    endtask

    initial begin : result_sink
        res_ack = 1'b0;
        forever begin
            next_cycle();
            if (res_req && !res_ack) begin
                score_result();
                repeat (ack_wait[res_tag]) next_cycle();
                res_ack = 1'b1;
                do next_cycle(); while (res_req);
                res_ack = 1'b0; // closes the handshake, alu free again
            end
        end
    end

    ////////////////////////////////////////
    // sections
    ////////////////////////////////////////

    task automatic open_section(int s);
        for (int t = 0; t < NTAGS; t++) begin
            sec_live[t] = 1'b0;
            seen_cnt[t] = 0;
            ack_wait[t] = 0;
        end
        for (int i = 0; i < n_rows; i++) begin
            if (row_sec[i] == s) begin
                sec_live[row_dst[i]] = 1'b1;
                tag_row[row_dst[i]]  = i;
                ack_wait[row_dst[i]] = (row_delay[i] < 0) ? int'($urandom % 6) : row_delay[i];
            end
        end
    endtask

    // wait for every tag, let the pipe go quiet, then count returns
    task automatic drain_section(int s);
        logic done;
        done = 1'b0;
        while (!done) begin
            next_cycle();
            done = 1'b1;
            for (int i = 0; i < n_rows; i++) begin
                if (row_sec[i] == s && seen_cnt[row_dst[i]] == 0) done = 1'b0;
            end
        end
        while (res_req || res_ack) next_cycle();
        repeat (4) next_cycle(); // room for a late duplicate
        for (int i = 0; i < n_rows; i++) begin
            if (row_sec[i] == s && seen_cnt[row_dst[i]] != 1) begin
                $display("row %s tag %0d came back %0d times instead of once",
                         row_name[i], row_dst[i], seen_cnt[row_dst[i]]);
                other_errs++;
            end
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin : watchdog
        while (cycle_cnt < LIMIT) begin
            @(posedge clock);
            cycle_cnt++;
        end
        $display("run hung, results still missing after %0d cycles", LIMIT);
        other_errs++;
        finish_run();
    end

    initial begin : main
        rst           = 1'b1;
        in_req        = 1'b0;
        in_func       = ALU_ADD;
        in_dst_tag    = '0;
        in_opa        = '0;
        in_opa_is_tag = 1'b0;
        in_opb        = '0;
        in_opb_is_tag = 1'b0;
        void'($urandom(32'hae83)); // single seed for the whole run
        build_table();
        resolve_rows();
        repeat (10) @(posedge clock);
        #2 rst = 1'b0;
        next_cycle();
        // quiet channels before any stimulus
        if (in_ack !== 1'b0) begin
            $display("mismatch after_reset in_ack expected 0 actual %b", in_ack);
            mismatches++;
        end
        if (res_req !== 1'b0) begin
            $display("mismatch after_reset res_req expected 0 actual %b", res_req);
            mismatches++;
        end
        for (int s = 0; s < NUM_SECS; s++) begin
            open_section(s);
            for (int i = 0; i < n_rows; i++) begin
                if (row_sec[i] == s) send_row(i);
            end
            drain_section(s);
        end
        finish_run();
    end

endmodule

// File: ooo_issue_top.sv
// out-of-order issue slice, top level
// dispatch -> reservation station -> issue select -> alu,
// with the alu result broadcast fed back to the station
`timescale 1ns/1ps

module ooo_issue_top #(
    parameter int RS_SIZE = ooo_pkg::RS_SIZE_DEF
) (
    input  logic                          clock,
    input  logic                          rst,
    // instruction channel
    input  logic                          in_req,
    output logic                          in_ack,
    input  isa_pkg::alu_func_e            in_func,
    input  logic [ooo_pkg::TAG_W-1:0]     in_dst_tag,
    input  logic [isa_pkg::XLEN-1:0]      in_opa,
    input  logic                          in_opa_is_tag,
    input  logic [isa_pkg::XLEN-1:0]      in_opb,
    input  logic                          in_opb_is_tag,
    // result channel
    output logic                          res_req,
    input  logic                          res_ack,
    output logic [ooo_pkg::TAG_W-1:0]     res_tag,
    output logic [isa_pkg::XLEN-1:0]      res_value
);
    import isa_pkg::*;
    import ooo_pkg::*;

    // dispatch to station
    logic                         alloc_en;
    logic [$clog2(RS_SIZE)-1:0]   alloc_idx;
    alu_func_e                    alloc_func;
    logic [TAG_W-1:0]             alloc_dst_tag;
    logic [XLEN-1:0]              alloc_opa;
    logic                         alloc_opa_wait;
    logic [XLEN-1:0]              alloc_opb;
    logic                         alloc_opb_wait;
    logic [RS_SIZE-1:0]           rs_busy;
    // station to issue
    logic [RS_SIZE-1:0]           rs_ready;
    logic [RS_SIZE-1:0][XLEN-1:0] rs_opa;
    logic [RS_SIZE-1:0][XLEN-1:0] rs_opb;
    alu_func_e [RS_SIZE-1:0]      rs_func;
    logic [RS_SIZE-1:0][TAG_W-1:0] rs_dst_tag;
    logic [RS_SIZE-1:0]           rs_issue_enable;
    // issue to alu
    logic                         fu_ready;
    logic                         issue_valid;
    alu_func_e                    iss_func;
    logic [XLEN-1:0]              iss_opa;
    logic [XLEN-1:0]              iss_opb;
    logic [TAG_W-1:0]             iss_tag;
    // broadcast
    logic                         wb_valid;
    logic [TAG_W-1:0]             wb_tag;
    logic [XLEN-1:0]              wb_value;

    dispatch_unit #(.RS_SIZE(RS_SIZE)) dispatch_unit_inst (
        .clock, .rst, .in_req, .in_ack, .in_func, .in_dst_tag,
        .in_opa, .in_opa_is_tag, .in_opb, .in_opb_is_tag,
        .rs_busy, .alloc_en, .alloc_idx, .alloc_func, .alloc_dst_tag,
        .alloc_opa, .alloc_opa_wait, .alloc_opb, .alloc_opb_wait
    );

    res_station #(.RS_SIZE(RS_SIZE)) res_station_inst (
        .clock, .rst, .alloc_en, .alloc_idx, .alloc_func, .alloc_dst_tag,
        .alloc_opa, .alloc_opa_wait, .alloc_opb, .alloc_opb_wait,
        .wb_valid, .wb_tag, .wb_value, .rs_issue_enable,
        .rs_busy, .rs_ready, .rs_opa, .rs_opb, .rs_func, .rs_dst_tag
    );

    stage_is #(.RS_SIZE(RS_SIZE)) stage_is_inst (
        .rs_ready, .rs_opa, .rs_opb, .rs_func, .rs_dst_tag, .fu_ready,
        .issue_valid, .iss_func, .iss_opa, .iss_opb, .iss_tag, .rs_issue_enable
    );

    alu_fu alu_fu_inst (
        .clock, .rst, .issue_valid, .iss_func, .iss_opa, .iss_opb, .iss_tag,
        .fu_ready, .wb_valid, .wb_tag, .wb_value,
        .res_req, .res_ack, .res_tag, .res_value
    );

endmodule

// File: alu_fu.sv
// alu functional unit
// one-cycle integer alu; registers result and tag, broadcasts them
// back to the station and offers them on a four-phase output channel
`timescale 1ns/1ps

module alu_fu (
    input  logic                          clock,
    input  logic                          rst,
    // from issue
    input  logic                          issue_valid,
    input  isa_pkg::alu_func_e            iss_func,
    input  logic [isa_pkg::XLEN-1:0]      iss_opa,
    input  logic [isa_pkg::XLEN-1:0]      iss_opb,
    input  logic [ooo_pkg::TAG_W-1:0]     iss_tag,
    output logic                          fu_ready,
    // broadcast to the station
    output logic                          wb_valid,
    output logic [ooo_pkg::TAG_W-1:0]     wb_tag,
    output logic [isa_pkg::XLEN-1:0]      wb_value,
    // result channel
    output logic                          res_req,
    input  logic                          res_ack,
    output logic [ooo_pkg::TAG_W-1:0]     res_tag,
    output logic [isa_pkg::XLEN-1:0]      res_value
);
    import isa_pkg::*;
    import ooo_pkg::*;

    // output handshake phases
    typedef enum logic [1:0] {
        FU_IDLE, // free for the next instruction
        FU_REQ,  // req high, waiting for ack
        FU_DROP  // req low, waiting for ack to fall
    } fu_state_e;

    fu_state_e        state;
    logic             take;     // instruction accepted this cycle
    logic [XLEN-1:0]  result;
    logic [XLEN-1:0]  value_q;
    logic [TAG_W-1:0] tag_q;

    assign fu_ready = (state == FU_IDLE);
    assign take     = issue_valid && fu_ready;

    always_comb begin
        case (iss_func)
            ALU_ADD: result = iss_opa + iss_opb;
            ALU_SUB: result = iss_opa - iss_opb;
            ALU_AND: result = iss_opa & iss_opb;
            ALU_OR:  result = iss_opa | iss_opb;
            ALU_XOR: result = iss_opa ^ iss_opb;
            ALU_SLL: result = iss_opa << iss_opb[4:0];
            ALU_SRL: result = iss_opa >> iss_opb[4:0];
            default: result = {XLEN{1'b0}};
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= FU_IDLE;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= take; // single cycle pulse
            case (state)
                FU_IDLE: if (take)     state <= FU_REQ;
                FU_REQ:  if (res_ack)  state <= FU_DROP;
                FU_DROP: if (!res_ack) state <= FU_IDLE; // handshake done
                default: state <= FU_IDLE;
            endcase
        end
    end

    // result and tag held until the next instruction
    always_ff @(posedge clock) begin
        if (take) begin
            value_q <= result;
            tag_q   <= iss_tag;
        end
    end

    assign res_req   = (state == FU_REQ);
    assign res_tag   = tag_q;
    assign res_value = value_q;
    assign wb_tag    = tag_q;
    assign wb_value  = value_q;

    // req only drops after the sink has acknowledged
    assert property (@(posedge clock) disable iff (rst)
        $fell(res_req) |-> $past(res_ack));

endmodule

// File: stage_is.sv
// issue stage
// picks the lowest-index ready station entry while the alu is free
// and hands it over; drives a zero packet otherwise
`timescale 1ns/1ps

module stage_is #(
    parameter int RS_SIZE = ooo_pkg::RS_SIZE_DEF
) (
    // station side
    input  logic [RS_SIZE-1:0]                        rs_ready,
    input  logic [RS_SIZE-1:0][isa_pkg::XLEN-1:0]     rs_opa,
    input  logic [RS_SIZE-1:0][isa_pkg::XLEN-1:0]     rs_opb,
    input  isa_pkg::alu_func_e [RS_SIZE-1:0]          rs_func,
    input  logic [RS_SIZE-1:0][ooo_pkg::TAG_W-1:0]    rs_dst_tag,
    // alu side
    input  logic                                      fu_ready,
    output logic                                      issue_valid,
    output isa_pkg::alu_func_e                        iss_func,
    output logic [isa_pkg::XLEN-1:0]                  iss_opa,
    output logic [isa_pkg::XLEN-1:0]                  iss_opb,
    output logic [ooo_pkg::TAG_W-1:0]                 iss_tag,
    // entry to free, one-hot
    output logic [RS_SIZE-1:0]                        rs_issue_enable
);
    import isa_pkg::*;
    import ooo_pkg::*;

    always_comb begin
        // idle packet
        issue_valid     = 1'b0;
        iss_func        = ALU_ADD;
        iss_opa         = {XLEN{1'b0}};
        iss_opb         = {XLEN{1'b0}};
        iss_tag         = {TAG_W{1'b0}};
        rs_issue_enable = '0;

        if (fu_ready) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (!issue_valid && rs_ready[i]) begin // first ready wins
                    issue_valid        = 1'b1;
                    iss_func           = rs_func[i];
                    iss_opa            = rs_opa[i];
                    iss_opb            = rs_opb[i];
                    iss_tag            = rs_dst_tag[i];
                    rs_issue_enable[i] = 1'b1;
                end
            end
        end
    end

endmodule

// File: res_station.sv
// reservation station
// holds up to RS_SIZE instructions, captures missing operands from
// the alu result broadcast and flags entries whose operands are all there
`timescale 1ns/1ps

module res_station #(
    parameter int RS_SIZE = ooo_pkg::RS_SIZE_DEF
) (
    input  logic                                      clock,
    input  logic                                      rst,
    // allocation from dispatch
    input  logic                                      alloc_en,
    input  logic [$clog2(RS_SIZE)-1:0]                alloc_idx,
    input  isa_pkg::alu_func_e                        alloc_func,
    input  logic [ooo_pkg::TAG_W-1:0]                 alloc_dst_tag,
    input  logic [isa_pkg::XLEN-1:0]                  alloc_opa,
    input  logic                                      alloc_opa_wait,
    input  logic [isa_pkg::XLEN-1:0]                  alloc_opb,
    input  logic                                      alloc_opb_wait,
    // result broadcast
    input  logic                                      wb_valid,
    input  logic [ooo_pkg::TAG_W-1:0]                 wb_tag,
    input  logic [isa_pkg::XLEN-1:0]                  wb_value,
    // issue side
    input  logic [RS_SIZE-1:0]                        rs_issue_enable,
    output logic [RS_SIZE-1:0]                        rs_busy,
    output logic [RS_SIZE-1:0]                        rs_ready,
    output logic [RS_SIZE-1:0][isa_pkg::XLEN-1:0]     rs_opa,
    output logic [RS_SIZE-1:0][isa_pkg::XLEN-1:0]     rs_opb,
    output isa_pkg::alu_func_e [RS_SIZE-1:0]          rs_func,
    output logic [RS_SIZE-1:0][ooo_pkg::TAG_W-1:0]    rs_dst_tag
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(RS_SIZE);

    logic [RS_SIZE-1:0] opa_wait;  // opa still holds a producer tag
    logic [RS_SIZE-1:0] opb_wait;
    logic [RS_SIZE-1:0] hit_a;     // broadcast matches a stored tag
    logic [RS_SIZE-1:0] hit_b;
    logic [RS_SIZE-1:0] wr_sel;    // entry written by dispatch this cycle
    logic               new_hit_a; // broadcast matches the incoming operand
    logic               new_hit_b;

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            hit_a[i]  = wb_valid && opa_wait[i] && (rs_opa[i][TAG_W-1:0] == wb_tag);
            hit_b[i]  = wb_valid && opb_wait[i] && (rs_opb[i][TAG_W-1:0] == wb_tag);
            wr_sel[i] = alloc_en && (alloc_idx == IDX_W'(i));
        end
    end

    // same-cycle capture so a consumer never misses its producer
    assign new_hit_a = wb_valid && alloc_opa_wait && (alloc_opa[TAG_W-1:0] == wb_tag);
    assign new_hit_b = wb_valid && alloc_opb_wait && (alloc_opb[TAG_W-1:0] == wb_tag);

    assign rs_ready = rs_busy & ~opa_wait & ~opb_wait;

    ////////////////////////////////////////
    // control, busy and wait flags
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            rs_busy  <= '0;
            opa_wait <= '0;
            opb_wait <= '0;
        end else begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (wr_sel[i]) begin
                    rs_busy[i]  <= 1'b1;
                    opa_wait[i] <= alloc_opa_wait && !new_hit_a;
                    opb_wait[i] <= alloc_opb_wait && !new_hit_b;
                end else begin
                    if (rs_issue_enable[i]) rs_busy[i]  <= 1'b0; // freed on issue
                    if (hit_a[i])           opa_wait[i] <= 1'b0; // wakeup
                    if (hit_b[i])           opb_wait[i] <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // payload
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (wr_sel[i]) begin
                rs_func[i]    <= alloc_func;
                rs_dst_tag[i] <= alloc_dst_tag;
                rs_opa[i]     <= new_hit_a ? wb_value : alloc_opa;
                rs_opb[i]     <= new_hit_b ? wb_value : alloc_opb;
            end else begin
                if (hit_a[i]) rs_opa[i] <= wb_value;
                if (hit_b[i]) rs_opb[i] <= wb_value;
            end
        end
    end

    // issue stage picks at most one entry, and only one with all operands
    assert property (@(posedge clock) disable iff (rst)
        $onehot0(rs_issue_enable) && ((rs_issue_enable & ~rs_ready) == '0));

endmodule

// File: dispatch_unit.sv
// dispatch unit
// takes instructions over a four-phase req/ack channel and writes
// each one into the lowest free reservation station entry;
// ack is withheld while the station is full
`timescale 1ns/1ps

module dispatch_unit #(
    parameter int RS_SIZE = ooo_pkg::RS_SIZE_DEF
) (
    input  logic                          clock,
    input  logic                          rst,
    // external channel
    input  logic                          in_req,
    output logic                          in_ack,
    input  isa_pkg::alu_func_e            in_func,
    input  logic [ooo_pkg::TAG_W-1:0]     in_dst_tag,
    input  logic [isa_pkg::XLEN-1:0]      in_opa,
    input  logic                          in_opa_is_tag,
    input  logic [isa_pkg::XLEN-1:0]      in_opb,
    input  logic                          in_opb_is_tag,
    // station side
    input  logic [RS_SIZE-1:0]            rs_busy,
    output logic                          alloc_en,
    output logic [$clog2(RS_SIZE)-1:0]    alloc_idx,
    output isa_pkg::alu_func_e            alloc_func,
    output logic [ooo_pkg::TAG_W-1:0]     alloc_dst_tag,
    output logic [isa_pkg::XLEN-1:0]      alloc_opa,
    output logic                          alloc_opa_wait,
    output logic [isa_pkg::XLEN-1:0]      alloc_opb,
    output logic                          alloc_opb_wait
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(RS_SIZE);

    disp_state_e      state;
    logic             req_q;      // in_req seen on the previous edge
    logic             free_found;
    logic [IDX_W-1:0] free_idx;

    // lowest free entry wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (!free_found && !rs_busy[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // write one edge after req is sampled while the source holds the fields
    assign alloc_en       = (state == DISP_IDLE) && req_q && in_req && free_found;
    assign alloc_idx      = free_idx;
    assign alloc_func     = in_func;
    assign alloc_dst_tag  = in_dst_tag;
    assign alloc_opa      = in_opa;     // low TAG_W bits name the producer if waiting
    assign alloc_opa_wait = in_opa_is_tag;
    assign alloc_opb      = in_opb;
    assign alloc_opb_wait = in_opb_is_tag;
    assign in_ack         = (state == DISP_ACK); // rises with the entry write

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= DISP_IDLE;
            req_q <= 1'b0;
        end else begin
            req_q <= in_req;
            case (state)
                DISP_IDLE: if (alloc_en) state <= DISP_ACK; // full station stalls here
                DISP_ACK:  if (!in_req)  state <= DISP_IDLE; // ack drops after req
                default:   state <= DISP_IDLE;
            endcase
        end
    end

    // never overwrite a live station entry
    assert property (@(posedge clock) disable iff (rst)
        alloc_en |-> !rs_busy[alloc_idx]);

endmodule

// File: ooo_pkg.sv
// out-of-order machine sizes
// result tag width, default station depth, dispatch FSM states
package ooo_pkg;

    // tag carried by each result, set by the outside world
    parameter int TAG_W = 4;

    // station depth when the top level is not overridden
    parameter int RS_SIZE_DEF = 4;

    // dispatch handshake FSM
    typedef enum logic {
        DISP_IDLE = 1'b0, // waiting for req and a free entry
        DISP_ACK  = 1'b1  // entry written, ack held until req drops
    } disp_state_e;

endpackage

// File: isa_pkg.sv
// ISA definitions for the issue slice
// ALU operation encoding and datapath width
package isa_pkg;

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    parameter int XLEN = 32; // operand and result width

    ////////////////////////////////////////
    // alu operations
    ////////////////////////////////////////

    // 3 bit opcode, one per alu function
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, // opa + opb
        ALU_SUB = 3'd1, // opa - opb
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5, // shift by opb[4:0]
        ALU_SRL = 3'd6  // logical, zero fill
    } alu_func_e;

endpackage
